// File: hcmp_macros.svh
`ifndef HCMP_MACROS_SVH
`define HCMP_MACROS_SVH

// binary16 operand layout
`define HALF_WIDTH 16 // Full operand
`define EXP_WIDTH 5   // Biased exponent field
`define MAN_WIDTH 10  // Stored fraction, hidden bit not included

// Compare opcode bus
`define OPCODE_WIDTH 5

// Parallel compares per capture
// Any positive count works; din0/din1 scale with it
`define NUM_LANES 4

// Derived widths
`define MAG_WIDTH (`EXP_WIDTH + `MAN_WIDTH) // Sign-less magnitude key
`define BUS_WIDTH (`NUM_LANES * `HALF_WIDTH) // Packed operand bus at top

// Slice helper for one lane of a packed operand bus
`define LANE_LSB(i) ((i) * `HALF_WIDTH)

`endif

// File: fpFormatPkg.sv
// Field view and operand classes for IEEE binary16
`include "hcmp_macros.svh"

package fpFormatPkg;

	// Sign, biased exponent, fraction; MSB first so it overlays a raw word
	typedef struct packed {
		logic                  sign;     // 1 = negative
		logic [`EXP_WIDTH-1:0] exponent; // All ones = inf/NaN
		logic [`MAN_WIDTH-1:0] mantissa; // Fraction bits
	} halfFloat_t;

	// Operand class, decided from exponent and fraction alone
	typedef enum logic [2:0] {
		FP_ZERO,      // Exp 0, frac 0, either sign
		FP_SUBNORMAL, // Exp 0, frac nonzero
		FP_NORMAL,    // Exp neither 0 nor all ones
		FP_INF,       // Exp all ones, frac 0
		FP_NAN        // Exp all ones, frac nonzero
	} fpClass_t;

	// Raw magnitude key; with equal signs this orders finite values and inf
	typedef logic [`MAG_WIDTH-1:0] fpMag_t;

	function automatic fpMag_t magOf(input halfFloat_t x);
		fpMag_t mag;
		mag = {x.exponent, x.mantissa}; // Exponent on top so a plain compare works
		return mag;
	endfunction

endpackage

// File: cmpOpPkg.sv
// Opcode encoding and compare outcome flags
`include "hcmp_macros.svh"

package cmpOpPkg;

	// Same codes as the HLS compare opcode bus
	// Codes 0, 7 and 9..31 are unlisted and decode as OP_OEQ
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		OP_OEQ = 1, // Ordered equal
		OP_OGT = 2, // Ordered greater
		OP_OGE = 3, // Ordered greater or equal
		OP_OLT = 4, // Ordered less
		OP_OLE = 5, // Ordered less or equal
		OP_ONE = 6, // Ordered not equal
		OP_UNO = 8  // Either operand NaN
	} cmpOp_t;

	// One-hot relation of a against b
	// Exactly one flag set for any operand pair
	typedef struct packed {
		logic less;
		logic equal;
		logic greater;
		logic unordered; // A NaN was seen, other flags stay low
	} cmpRel_t;

	// Fallback for anything not in the list above
	localparam cmpOp_t DEFAULT_OP = OP_OEQ;

endpackage

// File: laneIf.sv
`timescale 1ns/1ps

// One compare lane: operand pair and opcode in, one result bit out
interface laneIf import fpFormatPkg::*, cmpOpPkg::*; ();

	halfFloat_t a;      // Left operand
	halfFloat_t b;      // Right operand
	cmpOp_t     op;     // Decoded opcode, same on every lane
	logic       result; // Live compare outcome

	// Input register side
	modport issue (
		output a, b, op
	);

	// Comparator itself
	modport lane (
		input  a, b, op,
		output result
	);

	// Output gather and hold
	modport collect (
		input result
	);

endinterface

// File: cmpIssue.sv
`timescale 1ns/1ps
`include "hcmp_macros.svh"

// Input stage: capture under ce, split per lane, decode opcode once
module cmpIssue import fpFormatPkg::*, cmpOpPkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ce,
	input  logic [`BUS_WIDTH-1:0]    din0,
	input  logic [`BUS_WIDTH-1:0]    din1,
	input  logic [`OPCODE_WIDTH-1:0] opcode,
	laneIf.issue                     lanes [`NUM_LANES]
);

	logic [`BUS_WIDTH-1:0]    din0Reg;   // Captured left operands
	logic [`BUS_WIDTH-1:0]    din1Reg;   // Captured right operands
	logic [`OPCODE_WIDTH-1:0] opcodeReg; // Raw captured code
	cmpOp_t                   decodedOp;

	// Single register stage, frozen while ce is low
	always_ff @(posedge clk) begin
		if (rst) begin
			din0Reg   <= '0;
			din1Reg   <= '0;
			opcodeReg <= '0;
		end else if (ce) begin
			din0Reg   <= din0;
			din1Reg   <= din1;
			opcodeReg <= opcode;
		end
	end

	// Listed codes pass through, anything else acts as equal
	always_comb begin
		case (opcodeReg)
			OP_OEQ, OP_OGT, OP_OGE, OP_OLT,
			OP_OLE, OP_ONE, OP_UNO: begin
				decodedOp = cmpOp_t'(opcodeReg);
			end
			default: begin
				decodedOp = DEFAULT_OP; // 0, 7, 9..31
			end
		endcase
	end

	// Lane i takes slice i of each bus
	for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
		assign lanes[i].a  = halfFloat_t'(din0Reg[`LANE_LSB(i) +: `HALF_WIDTH]);
		assign lanes[i].b  = halfFloat_t'(din1Reg[`LANE_LSB(i) +: `HALF_WIDTH]);
		assign lanes[i].op = decodedOp; // Shared decode
	end

endmodule

// File: cmpLane.sv
`timescale 1ns/1ps
`include "hcmp_macros.svh"

// One binary16 comparator, purely combinational
module cmpLane import fpFormatPkg::*, cmpOpPkg::*; (
	laneIf.lane port
);

	fpClass_t             classA;
	fpClass_t             classB;
	logic [`MAG_WIDTH-1:0] magA;  // Exponent:fraction of a
	logic [`MAG_WIDTH-1:0] magB;
	logic                 magLess; // |a| < |b|
	cmpRel_t              rel;

	// Class from exponent and fraction, sign ignored
	function automatic fpClass_t classify(input halfFloat_t x);
		fpClass_t cls;
		if (x.exponent == '0) begin
			if (x.mantissa == '0)
				cls = FP_ZERO;
			else
				cls = FP_SUBNORMAL;
		end else if (x.exponent == '1) begin
			if (x.mantissa == '0)
				cls = FP_INF;
			else
				cls = FP_NAN; // Quiet and signaling alike
		end else begin
			cls = FP_NORMAL;
		end
		return cls;
	endfunction

	assign classA  = classify(port.a);
	assign classB  = classify(port.b);
	assign magA    = magOf(port.a);
	assign magB    = magOf(port.b);
	assign magLess = magA < magB; // Subnormals and inf fall in place

	// Relation of a to b
	always_comb begin
		rel = '0;
		if (classA == FP_NAN || classB == FP_NAN) begin
			rel.unordered = 1'b1; // Nothing ordered holds
		end else if ((classA == FP_ZERO && classB == FP_ZERO) || port.a == port.b) begin
			rel.equal = 1'b1; // +0 == -0
		end else if (port.a.sign != port.b.sign) begin
			// Both-zero case is gone, so the negative side is strictly smaller
			rel.less    = port.a.sign;
			rel.greater = port.b.sign;
		end else if (port.a.sign) begin
			// Two negatives, larger magnitude is the smaller value
			rel.less    = ~magLess;
			rel.greater = magLess;
		end else begin
			rel.less    = magLess;
			rel.greater = ~magLess;
		end
	end

	// Opcode picks from the relation
	// Unordered leaves less/equal/greater low, so ordered ops read false
	always_comb begin
		case (port.op)
			OP_OEQ:  port.result = rel.equal;
			OP_OGT:  port.result = rel.greater;
			OP_OGE:  port.result = rel.greater | rel.equal;
			OP_OLT:  port.result = rel.less;
			OP_OLE:  port.result = rel.less | rel.equal;
			OP_ONE:  port.result = rel.less | rel.greater;
			OP_UNO:  port.result = rel.unordered;
			default: port.result = rel.equal; // Decode never sends this
		endcase
	end

endmodule

// File: cmpCollect.sv
`timescale 1ns/1ps
`include "hcmp_macros.svh"

// Output stage: live lane results after a capture, held value otherwise
module cmpCollect (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,
	laneIf.collect                lanes [`NUM_LANES],
	output logic [`NUM_LANES-1:0] dout
);

	logic                  ceDly;   // Capture happened on the last edge
	logic [`NUM_LANES-1:0] liveVec; // Current lane results
	logic [`NUM_LANES-1:0] holdReg; // Last shown result

	// Gather one bit per lane
	for (genvar i = 0; i < `NUM_LANES; i++) begin : gGather
		assign liveVec[i] = lanes[i].result;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ceDly <= 1'b0;
		else
			ceDly <= ce;
	end

	// Snapshot whatever was on dout during a live cycle
	always_ff @(posedge clk) begin
		if (rst)
			holdReg <= '0; // dout reads zero until first capture
		else if (ceDly)
			holdReg <= liveVec;
	end

	// Live for one cycle after each capture edge
	// Held otherwise, even though the input regs did not move
	assign dout = ceDly ? liveVec : holdReg;

endmodule

// File: hcmpTop.sv
`timescale 1ns/1ps
`include "hcmp_macros.svh"

// Four-lane binary16 compare with ce capture and output hold
// Latency is one cycle from a ce-high edge to dout
module hcmpTop (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ce,
	input  logic [`BUS_WIDTH-1:0]    din0,   // Lane i at slice i
	input  logic [`BUS_WIDTH-1:0]    din1,
	input  logic [`OPCODE_WIDTH-1:0] opcode, // Shared by all lanes
	output logic [`NUM_LANES-1:0]    dout    // One bit per lane
);

	laneIf lanes [`NUM_LANES] ();

	cmpIssue issueInst (
		.clk    (clk),
		.rst    (rst),
		.ce     (ce),
		.din0   (din0),
		.din1   (din1),
		.opcode (opcode),
		.lanes  (lanes)
	);

	// Identical comparators, one per lane
	for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
		cmpLane laneInst (
			.port (lanes[i])
		);
	end

	cmpCollect collectInst (
		.clk   (clk),
		.rst   (rst),
		.ce    (ce),
		.lanes (lanes),
		.dout  (dout)
	);

endmodule

// File: tbHcmp.sv
`timescale 1ns/1ps
`include "hcmp_macros.svh"

// Directed testbench for the four-lane binary16 compare
module tbHcmp import cmpOpPkg::*; ();

	logic                     clk;
	logic                     rst;
	logic                     ce;
	logic [`BUS_WIDTH-1:0]    din0;
	logic [`BUS_WIDTH-1:0]    din1;
	logic [`OPCODE_WIDTH-1:0] opcode;
	logic [`NUM_LANES-1:0]    dout;
	integer                   seed; // $random state

	hcmpTop uut (
		.clk    (clk),
		.rst    (rst),
		.ce     (ce),
		.din0   (din0),
		.din1   (din1),
		.opcode (opcode),
		.dout   (dout)
	);

	always #2 clk = ~clk; // 4 ns period

	// NaN unorders, otherwise order by signed magnitude key
	function automatic logic refCompare(input logic [15:0] a, input logic [15:0] b,
			input logic [`OPCODE_WIDTH-1:0] code);
		cmpRel_t            rel;
		logic               nanA;
		logic               nanB;
		logic signed [16:0] keyA;
		logic signed [16:0] keyB;
		logic               res;
		nanA = (a[14:10] == 5'h1f) && (a[9:0] != 10'h0);
		nanB = (b[14:10] == 5'h1f) && (b[9:0] != 10'h0);
		keyA = a[15] ? -$signed({2'b00, a[14:0]}) : $signed({2'b00, a[14:0]}); // -0 maps to 0
		keyB = b[15] ? -$signed({2'b00, b[14:0]}) : $signed({2'b00, b[14:0]});
		rel  = '0;
		if (nanA || nanB)
			rel.unordered = 1'b1;
		else if (keyA < keyB)
			rel.less = 1'b1;
		else if (keyA > keyB)
			rel.greater = 1'b1;
		else
			rel.equal = 1'b1;
		case (code)
			OP_OGT:  res = rel.greater;
			OP_OGE:  res = rel.greater | rel.equal;
			OP_OLT:  res = rel.less;
			OP_OLE:  res = rel.less | rel.equal;
			OP_ONE:  res = rel.less | rel.greater;
			OP_UNO:  res = rel.unordered;
			default: res = rel.equal; // Equal and every unlisted code
		endcase
		return res;
	endfunction

	// Expected dout for a whole capture
	function automatic logic [`NUM_LANES-1:0] expVec(input logic [`BUS_WIDTH-1:0] bus0,
			input logic [`BUS_WIDTH-1:0] bus1, input logic [`OPCODE_WIDTH-1:0] code);
		logic [`NUM_LANES-1:0] v;
		for (int i = 0; i < `NUM_LANES; i++)
			v[i] = refCompare(bus0[i*16 +: 16], bus1[i*16 +: 16], code);
		return v;
	endfunction

	function automatic logic [15:0] randHalf();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Listed opcodes by index, 0..6
	function automatic logic [`OPCODE_WIDTH-1:0] opAt(input int k);
		cmpOp_t op;
		case (k)
			1:       op = OP_OGT;
			2:       op = OP_OGE;
			3:       op = OP_OLT;
			4:       op = OP_OLE;
			5:       op = OP_ONE;
			6:       op = OP_UNO;
			default: op = OP_OEQ;
		endcase
		return op;
	endfunction

	function automatic logic [`OPCODE_WIDTH-1:0] randOp();
		logic [15:0] r;
		r = randHalf();
		return opAt(int'(r[2:0])); // Index 7 folds onto equal
	endfunction

	// Random buses, roughly one lane in four forced equal
	task automatic randPair(output logic [`BUS_WIDTH-1:0] bus0,
			output logic [`BUS_WIDTH-1:0] bus1);
		logic [15:0] x;
		logic [15:0] sel;
		for (int i = 0; i < `NUM_LANES; i++) begin
			x   = randHalf();
			sel = randHalf();
			bus0[i*16 +: 16] = x;
			bus1[i*16 +: 16] = (sel[1:0] == 2'b00) ? x : randHalf();
		end
	endtask

	task automatic checkValue(input string name, input logic [`NUM_LANES-1:0] got,
			input logic [`NUM_LANES-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// One capture, ce dropped after it, dout checked in the live cycle
	task automatic applyAndCheck(input logic [`BUS_WIDTH-1:0] bus0,
			input logic [`BUS_WIDTH-1:0] bus1, input logic [`OPCODE_WIDTH-1:0] code,
			input logic [`NUM_LANES-1:0] exp);
		@(posedge clk);
		din0   <= bus0;
		din1   <= bus1;
		opcode <= code;
		ce     <= 1'b1;
		@(posedge clk); // Capture edge
		ce <= 1'b0;
		@(negedge clk);
		checkValue("dout", dout, exp);
	endtask

	task automatic resetClears();
		int cnt;
		cnt = 0;
		while (dout !== '0) begin
			@(posedge clk);
			cnt++;
			if (cnt > 20) begin
				$display("Timeout waiting for dout to clear after reset");
				$display("STATUS: FAIL");
				$fatal(1, "reset wait timed out");
			end
		end
		repeat (3) @(posedge clk); // ce still low
		@(negedge clk);
		checkValue("dout", dout, '0);
	endtask

	// Lanes: 1<2, 3==3, 4>0.5, -1<1
	task automatic sweepOpcodes();
		logic [`BUS_WIDTH-1:0] a;
		logic [`BUS_WIDTH-1:0] b;
		a = {16'hbc00, 16'h4400, 16'h4200, 16'h3c00};
		b = {16'h3c00, 16'h3800, 16'h4200, 16'h4000};
		for (int k = 0; k < 7; k++)
			applyAndCheck(a, b, opAt(k), expVec(a, b, opAt(k)));
	endtask

	// Lanes: +0/-0, subnormal/min normal, inf/max normal, NaN/1.0
	task automatic specialOperands();
		logic [`BUS_WIDTH-1:0] a;
		logic [`BUS_WIDTH-1:0] b;
		logic [3:0]            tab [7];
		a   = {16'h7e00, 16'h7c00, 16'h03ff, 16'h0000};
		b   = {16'h3c00, 16'h7bff, 16'h0400, 16'h8000};
		tab = '{4'b0001, 4'b0100, 4'b0101, 4'b0010, 4'b0011, 4'b0110, 4'b1000};
		for (int k = 0; k < 7; k++)
			applyAndCheck(a, b, opAt(k), tab[k]);
	endtask

	// Back-to-back captures, each checked one cycle later
	task automatic randomStream();
		logic [`BUS_WIDTH-1:0]    a;
		logic [`BUS_WIDTH-1:0]    b;
		logic [`OPCODE_WIDTH-1:0] op;
		logic [`NUM_LANES-1:0]    prevExp;
		for (int i = 0; i <= 200; i++) begin
			@(posedge clk); // Captures item i-1
			if (i < 200) begin
				randPair(a, b);
				op     = randOp();
				din0   <= a;
				din1   <= b;
				opcode <= op;
				ce     <= 1'b1;
			end else begin
				ce <= 1'b0;
			end
			@(negedge clk);
			if (i > 0)
				checkValue("dout", dout, prevExp);
			prevExp = expVec(a, b, op);
		end
	endtask

	task automatic holdWhileIdle();
		logic [`BUS_WIDTH-1:0] a;
		logic [`BUS_WIDTH-1:0] b;
		logic [`BUS_WIDTH-1:0] noiseA;
		logic [`BUS_WIDTH-1:0] noiseB;
		logic [15:0]           r;
		logic [`NUM_LANES-1:0] held;
		randPair(a, b);
		held = expVec(a, b, OP_OLE);
		applyAndCheck(a, b, OP_OLE, held);
		for (int i = 0; i < 6; i++) begin
			randPair(noiseA, noiseB);
			r = randHalf();
			@(posedge clk);
			din0   <= noiseA;
			din1   <= noiseB;
			opcode <= r[`OPCODE_WIDTH-1:0]; // Any 5-bit code
			@(negedge clk);
			checkValue("dout", dout, held); // Frozen
		end
		randPair(a, b);
		applyAndCheck(a, b, OP_OGT, expVec(a, b, OP_OGT));
	endtask

	// Unlisted codes must match the equal opcode
	// Lanes: NaN/1.0, -0/+0, 4>0.5, -1<1 so every listed op differs from equal
	task automatic unknownOpFold();
		logic [`BUS_WIDTH-1:0] a;
		logic [`BUS_WIDTH-1:0] b;
		logic [`NUM_LANES-1:0] eqRef;
		a = {16'hbc00, 16'h4400, 16'h8000, 16'h7e00};
		b = {16'h3c00, 16'h3800, 16'h0000, 16'h3c00};
		eqRef = expVec(a, b, OP_OEQ);
		applyAndCheck(a, b, OP_OEQ, eqRef);
		applyAndCheck(a, b, 5'd0, eqRef);
		applyAndCheck(a, b, 5'd7, eqRef);
		applyAndCheck(a, b, 5'd9, eqRef);
		applyAndCheck(a, b, 5'd31, eqRef);
	endtask

	initial begin
		seed   = 32'hacce_d4c9;
		clk    = 1'b0;
		rst    <= 1'b1;
		ce     <= 1'b0;
		din0   <= '0;
		din1   <= '0;
		opcode <= '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		resetClears();
		sweepOpcodes();
		specialOperands();
		randomStream();
		holdWhileIdle();
		unknownOpFold();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
fpFormatPkg.sv
cmpOpPkg.sv
laneIf.sv
cmpIssue.sv
cmpLane.sv
cmpCollect.sv
hcmpTop.sv
tbHcmp.sv

// File: Makefile
# Verilator build of the half-precision compare testbench

OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tbHcmp \
		-f filelist.f --Mdir $(OBJ) -o simv

# $fatal gives a nonzero exit status
run: compile
	./$(OBJ)/simv

clean:
	rm -rf $(OBJ)
